//--- logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

	localparam int tag_w = 6;
	localparam int data_w = 32;
	localparam int ticket_w = 3;
	localparam int op_w = 2;
	localparam int num_regs = 1 << tag_w;

	typedef enum logic [op_w-1:0] {
		op_add,
		op_sub,
		op_and,
		op_xor
	} op_e;

	typedef enum logic {
		fu_int,
		fu_mem
	} fu_e;

	// Register form of operand 2, tag in the low bits
	typedef struct packed {
		logic [data_w-tag_w-1:0] pad;
		logic [tag_w-1:0] tag;
	} src_tag_t;

	typedef union packed {
		logic [data_w-1:0] imm;
		src_tag_t src;
	} operand2_u;

	typedef struct packed {
		logic valid;
		fu_e fu;
		op_e op;
		logic [tag_w-1:0] dest;
		logic [tag_w-1:0] src1;
		logic src2_is_imm;
		operand2_u opnd2;
		logic [ticket_w-1:0] ticket;
	} renamed_instr_t;

	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] dest;
		logic [data_w-1:0] data;
	} wb_t;

	typedef struct packed {
		renamed_instr_t instr;
		logic pend1;
		logic pend2;
	} rs_entry_t;

	typedef struct packed {
		logic valid;
		op_e op;
		logic [tag_w-1:0] dest;
		logic [ticket_w-1:0] ticket;
		logic [data_w-1:0] data1;
		logic [data_w-1:0] data2;
	} exec_t;

endpackage

`default_nettype wire

//--- logic/reg_status.sv
`timescale 1ns/1ns
`default_nettype none

module reg_status #(
	parameter int wb_port_count = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] set_valid,
	input  logic [1:0][issue_pkg::tag_w-1:0] set_tag,
	input  issue_pkg::wb_t [wb_port_count-1:0] wb,
	output logic [issue_pkg::num_regs-1:0] pending
);

	logic [issue_pkg::num_regs-1:0] pending_next;

	always_comb begin
		pending_next = pending;
		// Writebacks clear first so a new destination set on the same edge wins
		for (int p = 0; p < wb_port_count; p++) begin
			if (wb[p].valid) begin
				pending_next[wb[p].dest] = 1'b0;
			end
		end
		for (int i = 0; i < 2; i++) begin
			if (set_valid[i]) begin
				pending_next[set_tag[i]] = 1'b1;
			end
		end
		// Register 0 never waits for a result
		pending_next[0] = 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			pending <= pending_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/phys_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module phys_regfile #(
	parameter int wb_port_count = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  issue_pkg::wb_t [wb_port_count-1:0] wb,
	input  logic [3:0][issue_pkg::tag_w-1:0] rd_tag,
	output logic [3:0][issue_pkg::data_w-1:0] rd_data
);

	logic [issue_pkg::data_w-1:0] regs [issue_pkg::num_regs];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < issue_pkg::num_regs; r++) begin
				regs[r] <= '0;
			end
		end else begin
			// Higher port wins on a clash, register 0 stays zero
			for (int p = 0; p < wb_port_count; p++) begin
				if (wb[p].valid && wb[p].dest != '0) begin
					regs[wb[p].dest] <= wb[p].data;
				end
			end
		end
	end

	// No bypass, a write shows up on the next cycle
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			rd_data[i] = regs[rd_tag[i]];
		end
	end

endmodule

`default_nettype wire

//--- logic/dispatch_router.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_router #(
	parameter int wb_port_count = 2
) (
	input  issue_pkg::renamed_instr_t [1:0] instr,
	input  logic valid_1,
	input  logic valid_2,
	input  logic [issue_pkg::num_regs-1:0] pending,
	input  issue_pkg::wb_t [wb_port_count-1:0] wb,
	input  logic [1:0] free_int,
	input  logic [1:0] free_mem,
	output logic issue_1,
	output logic issue_2,
	output logic [1:0] push_int,
	output logic [1:0] push_mem,
	output issue_pkg::rs_entry_t [1:0] entry
);

	logic [1:0] v;
	logic [1:0] free_1;
	logic [1:0] free_2;
	logic room_2;
	logic [1:0][issue_pkg::tag_w-1:0] tag1;
	logic [1:0][issue_pkg::tag_w-1:0] tag2;
	logic [1:0] hit1;
	logic [1:0] hit2;
	logic [1:0] dep1;
	logic [1:0] dep2;

	assign v = {valid_2 & instr[1].valid, valid_1 & instr[0].valid};
	assign free_1 = (instr[0].fu == issue_pkg::fu_int) ? free_int : free_mem;
	assign free_2 = (instr[1].fu == issue_pkg::fu_int) ? free_int : free_mem;

	// Second one needs two slots when sharing a station with an accepted first
	assign room_2 = (issue_1 && instr[0].fu == instr[1].fu) ? (free_2 >= 2'd2) : (free_2 != 2'd0);

	assign issue_1 = v[0] && free_1 != 2'd0;
	assign issue_2 = v[1] && (issue_1 || !v[0]) && room_2;

	assign push_int = {issue_2 && instr[1].fu == issue_pkg::fu_int,
		issue_1 && instr[0].fu == issue_pkg::fu_int};
	assign push_mem = {issue_2 && instr[1].fu == issue_pkg::fu_mem,
		issue_1 && instr[0].fu == issue_pkg::fu_mem};

	// Younger instruction depends on the older one's destination
	assign dep1 = {v[0] && |instr[0].dest && instr[1].src1 == instr[0].dest, 1'b0};
	assign dep2 = {v[0] && |instr[0].dest && instr[1].opnd2.src.tag == instr[0].dest, 1'b0};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			tag1[i] = instr[i].src1;
			tag2[i] = instr[i].opnd2.src.tag;
			hit1[i] = 1'b0;
			hit2[i] = 1'b0;
			for (int p = 0; p < wb_port_count; p++) begin
				if (wb[p].valid && wb[p].dest == tag1[i]) begin
					hit1[i] = 1'b1;
				end
				if (wb[p].valid && wb[p].dest == tag2[i]) begin
					hit2[i] = 1'b1;
				end
			end
			entry[i].instr = instr[i];
			entry[i].pend1 = |tag1[i] && (pending[tag1[i]] || dep1[i]) && !hit1[i];
			entry[i].pend2 = |tag2[i] && !instr[i].src2_is_imm
				&& (pending[tag2[i]] || dep2[i]) && !hit2[i];
		end
	end

endmodule

`default_nettype wire

//--- logic/reservation_station.sv
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
	parameter int rs_depth = 4,
	parameter int wb_port_count = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] push,
	input  issue_pkg::rs_entry_t [1:0] entry,
	output logic [1:0] free,
	input  issue_pkg::wb_t [wb_port_count-1:0] wb,
	input  logic busy,
	input  logic [issue_pkg::data_w-1:0] rd_data1,
	input  logic [issue_pkg::data_w-1:0] rd_data2,
	output logic [issue_pkg::tag_w-1:0] rd_tag1,
	output logic [issue_pkg::tag_w-1:0] rd_tag2,
	output issue_pkg::exec_t exec
);

	localparam int idx_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

	issue_pkg::rs_entry_t slots [rs_depth];
	issue_pkg::rs_entry_t head;
	issue_pkg::rs_entry_t entry_a;
	logic [rs_depth-1:0] used;
	logic [rs_depth-1:0] rdy;
	logic [idx_w-1:0] slot_a;
	logic [idx_w-1:0] slot_b;
	logic [idx_w-1:0] sel;
	logic found_a;
	logic found_b;
	logic any_rdy;
	logic wr_a;
	logic wr_b;

	// Two lowest free slots
	always_comb begin
		slot_a = '0;
		slot_b = '0;
		found_a = 1'b0;
		found_b = 1'b0;
		for (int i = 0; i < rs_depth; i++) begin
			if (!used[i]) begin
				if (!found_a) begin
					slot_a = idx_w'(i);
					found_a = 1'b1;
				end else if (!found_b) begin
					slot_b = idx_w'(i);
					found_b = 1'b1;
				end
			end
		end
	end

	assign free = found_b ? 2'd2 : {1'b0, found_a};

	// A lone push on port 1 still lands in the lowest free slot
	assign wr_a = push[0] | push[1];
	assign wr_b = push[0] & push[1];
	assign entry_a = push[0] ? entry[0] : entry[1];

	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			rdy[i] = used[i] && !slots[i].pend1 && !slots[i].pend2;
		end
	end

	always_comb begin
		sel = '0;
		any_rdy = 1'b0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (rdy[i]) begin
				sel = idx_w'(i);
				any_rdy = 1'b1;
			end
		end
	end

	assign head = slots[sel];
	assign rd_tag1 = head.instr.src1;
	assign rd_tag2 = head.instr.opnd2.src.tag;

	always_comb begin
		exec.valid = any_rdy & ~busy;
		exec.op = head.instr.op;
		exec.dest = head.instr.dest;
		exec.ticket = head.instr.ticket;
		exec.data1 = rd_data1;
		exec.data2 = head.instr.src2_is_imm ? head.instr.opnd2.imm : rd_data2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			used <= '0;
		end else begin
			if (exec.valid) begin
				used[sel] <= 1'b0;
			end
			if (wr_a) begin
				used[slot_a] <= 1'b1;
			end
			if (wr_b) begin
				used[slot_b] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		// Tag wakeup
		for (int i = 0; i < rs_depth; i++) begin
			for (int p = 0; p < wb_port_count; p++) begin
				if (wb[p].valid && wb[p].dest == slots[i].instr.src1) begin
					slots[i].pend1 <= 1'b0;
				end
				if (wb[p].valid && wb[p].dest == slots[i].instr.opnd2.src.tag) begin
					slots[i].pend2 <= 1'b0;
				end
			end
		end
		if (wr_a) begin
			slots[slot_a] <= entry_a;
		end
		if (wr_b) begin
			slots[slot_b] <= entry[1];
		end
	end

endmodule

`default_nettype wire

//--- logic/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage #(
	parameter int rs_depth = 4,
	parameter int wb_port_count = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  issue_pkg::renamed_instr_t [1:0] instr,
	input  logic valid_1,
	input  logic valid_2,
	input  issue_pkg::wb_t [wb_port_count-1:0] wb,
	input  logic busy_int,
	input  logic busy_mem,
	output logic issue_1,
	output logic issue_2,
	output issue_pkg::exec_t exec_int,
	output issue_pkg::exec_t exec_mem
);

	logic [issue_pkg::num_regs-1:0] pending;
	logic [1:0] free_int;
	logic [1:0] free_mem;
	logic [1:0] push_int;
	logic [1:0] push_mem;
	issue_pkg::rs_entry_t [1:0] entry;
	logic [issue_pkg::tag_w-1:0] int_tag1;
	logic [issue_pkg::tag_w-1:0] int_tag2;
	logic [issue_pkg::tag_w-1:0] mem_tag1;
	logic [issue_pkg::tag_w-1:0] mem_tag2;
	logic [3:0][issue_pkg::data_w-1:0] rd_data;

	reg_status #(.wb_port_count(wb_port_count)) u_reg_status (
		.clk(clk),
		.rst_n(rst_n),
		.set_valid({issue_2, issue_1}),
		.set_tag({instr[1].dest, instr[0].dest}),
		.wb(wb),
		.pending(pending)
	);

	// Read ports 0 and 1 serve the integer station, 2 and 3 the memory station
	phys_regfile #(.wb_port_count(wb_port_count)) u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.wb(wb),
		.rd_tag({mem_tag2, mem_tag1, int_tag2, int_tag1}),
		.rd_data(rd_data)
	);

	dispatch_router #(.wb_port_count(wb_port_count)) u_router (
		.instr(instr),
		.valid_1(valid_1),
		.valid_2(valid_2),
		.pending(pending),
		.wb(wb),
		.free_int(free_int),
		.free_mem(free_mem),
		.issue_1(issue_1),
		.issue_2(issue_2),
		.push_int(push_int),
		.push_mem(push_mem),
		.entry(entry)
	);

	reservation_station #(.rs_depth(rs_depth), .wb_port_count(wb_port_count)) u_rs_int (
		.clk(clk),
		.rst_n(rst_n),
		.push(push_int),
		.entry(entry),
		.free(free_int),
		.wb(wb),
		.busy(busy_int),
		.rd_data1(rd_data[0]),
		.rd_data2(rd_data[1]),
		.rd_tag1(int_tag1),
		.rd_tag2(int_tag2),
		.exec(exec_int)
	);

	reservation_station #(.rs_depth(rs_depth), .wb_port_count(wb_port_count)) u_rs_mem (
		.clk(clk),
		.rst_n(rst_n),
		.push(push_mem),
		.entry(entry),
		.free(free_mem),
		.wb(wb),
		.busy(busy_mem),
		.rd_data1(rd_data[2]),
		.rd_data2(rd_data[3]),
		.rd_tag1(mem_tag1),
		.rd_tag2(mem_tag2),
		.exec(exec_mem)
	);

endmodule

`default_nettype wire

//--- verification/issue_chk.sv
`timescale 1ns/1ns
`default_nettype none

module issue_chk (
	input  logic clk,
	input  logic rst_n,
	input  logic valid_1,
	input  logic issue_1,
	input  logic issue_2,
	input  logic busy_int,
	input  logic busy_mem,
	input  issue_pkg::exec_t exec_int,
	input  issue_pkg::exec_t exec_mem
);

	// Younger instruction never overtakes a waiting older one
	a_pair_order: assert property (@(posedge clk) disable iff (!rst_n)
		issue_2 |-> (issue_1 || !valid_1))
		else $error("issue_2 accepted while instruction 1 waits");

	a_busy_int: assert property (@(posedge clk) disable iff (!rst_n)
		busy_int |-> !exec_int.valid)
		else $error("exec_int valid while busy_int is high");

	a_busy_mem: assert property (@(posedge clk) disable iff (!rst_n)
		busy_mem |-> !exec_mem.valid)
		else $error("exec_mem valid while busy_mem is high");

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> (!issue_1 && !issue_2))
		else $error("issue strobe during reset");

endmodule

`default_nettype wire

//--- verification/issue_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module issue_monitor (
	input  logic clk,
	input  logic rst_n,
	input  issue_pkg::renamed_instr_t [1:0] instr,
	input  logic issue_1,
	input  logic issue_2,
	input  issue_pkg::exec_t exec_int,
	input  issue_pkg::exec_t exec_mem,
	output int errors,
	output int issued
);

	logic [31:0] ref_val [64];
	logic [31:0] exp1 [64];
	logic [31:0] exp2 [64];
	issue_pkg::op_e exp_op [64];
	logic [issue_pkg::ticket_w-1:0] exp_ticket [64];
	bit outstanding [64];

	function automatic logic [31:0] ref_alu(input issue_pkg::op_e op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			issue_pkg::op_add: return a + b;
			issue_pkg::op_sub: return a - b;
			issue_pkg::op_and: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	// Expected operands are fixed in program order at acceptance
	task automatic record(input issue_pkg::renamed_instr_t r);
		logic [31:0] a;
		logic [31:0] b;
		issue_pkg::op_e op;
		a = ref_val[r.src1];
		b = r.src2_is_imm ? r.opnd2.imm : ref_val[r.opnd2.src.tag];
		op = (r.fu == issue_pkg::fu_mem) ? issue_pkg::op_add : r.op;
		exp1[r.dest] = a;
		exp2[r.dest] = b;
		exp_op[r.dest] = r.op;
		exp_ticket[r.dest] = r.ticket;
		outstanding[r.dest] = 1'b1;
		if (r.dest != '0) begin
			ref_val[r.dest] = ref_alu(op, a, b);
		end
	endtask

	task automatic check_exec(input issue_pkg::exec_t e);
		if (e.valid) begin
			if (!outstanding[e.dest]) begin
				$display("Issue for dest %0d with no accepted instruction waiting", e.dest);
				errors++;
			end else begin
				if (e.data1 !== exp1[e.dest]) begin
					$display("Error: data1 dest %0d got %h expected %h", e.dest, e.data1,
						exp1[e.dest]);
					errors++;
				end
				if (e.data2 !== exp2[e.dest]) begin
					$display("Error: data2 dest %0d got %h expected %h", e.dest, e.data2,
						exp2[e.dest]);
					errors++;
				end
				if (e.op !== exp_op[e.dest]) begin
					$display("Error: op dest %0d got %h expected %h", e.dest, e.op,
						exp_op[e.dest]);
					errors++;
				end
				if (e.ticket !== exp_ticket[e.dest]) begin
					$display("Error: ticket dest %0d got %h expected %h", e.dest, e.ticket,
						exp_ticket[e.dest]);
					errors++;
				end
				outstanding[e.dest] = 1'b0;
				issued++;
			end
		end
	endtask

	initial begin
		errors = 0;
		issued = 0;
		for (int i = 0; i < 64; i++) begin
			ref_val[i] = '0;
			outstanding[i] = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			check_exec(exec_int);
			check_exec(exec_mem);
			if (issue_1) begin
				record(instr[0]);
			end
			if (issue_2) begin
				record(instr[1]);
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/issue_tb.sv
`timescale 1ns/1ns
`default_nettype none

module issue_tb;

	logic clk;
	logic rst_n;
	issue_pkg::renamed_instr_t [1:0] instr;
	logic valid_1;
	logic valid_2;
	issue_pkg::wb_t [1:0] wb;
	logic busy_int;
	logic busy_mem;
	logic issue_1;
	logic issue_2;
	issue_pkg::exec_t exec_int;
	issue_pkg::exec_t exec_mem;
	int mon_errors;
	int mon_issued;

	logic [31:0] seed;
	int errors;
	int accepted;
	issue_pkg::renamed_instr_t slot [2];
	bit slot_v [2];
	// Tag bookkeeping for renaming and the functional-unit model
	bit inflight [64];
	int readers [64];
	logic [5:0] src_a [64];
	logic [5:0] src_b [64];
	issue_pkg::fu_e unit [64];
	bit wb_wait [64];
	int wb_delay [64];
	logic [31:0] wb_data [64];

	issue_stage #(.rs_depth(4), .wb_port_count(2)) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.valid_1(valid_1),
		.valid_2(valid_2),
		.wb(wb),
		.busy_int(busy_int),
		.busy_mem(busy_mem),
		.issue_1(issue_1),
		.issue_2(issue_2),
		.exec_int(exec_int),
		.exec_mem(exec_mem)
	);

	issue_monitor u_mon (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.issue_1(issue_1),
		.issue_2(issue_2),
		.exec_int(exec_int),
		.exec_mem(exec_mem),
		.errors(mon_errors),
		.issued(mon_issued)
	);

	bind issue_stage issue_chk u_chk (
		.clk(clk),
		.rst_n(rst_n),
		.valid_1(valid_1),
		.issue_1(issue_1),
		.issue_2(issue_2),
		.busy_int(busy_int),
		.busy_mem(busy_mem),
		.exec_int(exec_int),
		.exec_mem(exec_mem)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic logic [31:0] ref_alu(input issue_pkg::op_e op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			issue_pkg::op_add: return a + b;
			issue_pkg::op_sub: return a - b;
			issue_pkg::op_and: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	// Free tag that nobody awaits or still has to read
	task automatic pick_dest(output bit ok, output logic [5:0] d);
		int start;
		int t;
		ok = 1'b0;
		d = '0;
		start = int'(next_rand() % 63);
		for (int i = 0; i < 63; i++) begin
			t = 1 + (start + i) % 63;
			if (!ok && !inflight[t] && readers[t] == 0) begin
				ok = 1'b1;
				d = 6'(t);
			end
		end
	endtask

	task automatic make_instr(input issue_pkg::fu_e fu, input issue_pkg::op_e op,
		input logic [5:0] dest, input logic [5:0] s1, input bit is_imm, input logic [31:0] v2,
		output issue_pkg::renamed_instr_t r);
		logic [5:0] a;
		logic [5:0] b;
		a = (s1 == dest) ? 6'd0 : s1;
		b = (is_imm || v2[5:0] == dest) ? 6'd0 : v2[5:0];
		r = '0;
		r.valid = 1'b1;
		r.fu = fu;
		r.op = op;
		r.dest = dest;
		r.src1 = a;
		r.src2_is_imm = is_imm;
		if (is_imm) begin
			r.opnd2.imm = v2;
		end else begin
			r.opnd2.src.tag = b;
		end
		r.ticket = 3'(accepted);
		inflight[dest] = 1'b1;
		unit[dest] = fu;
		src_a[dest] = a;
		src_b[dest] = b;
		readers[a]++;
		readers[b]++;
	endtask

	task automatic gen_random(output bit ok, output issue_pkg::renamed_instr_t r);
		logic [5:0] d;
		logic [31:0] x;
		r = '0;
		pick_dest(ok, d);
		if (ok) begin
			x = next_rand();
			make_instr(issue_pkg::fu_e'(x[0]), issue_pkg::op_e'(x[2:1]), d, x[9:4], x[3],
				x[3] ? next_rand() : {26'd0, x[15:10]}, r);
		end
	endtask

	task automatic present();
		instr[0] = slot[0];
		instr[0].valid = slot_v[0];
		instr[1] = slot[1];
		instr[1].valid = slot_v[1];
		valid_1 = slot_v[0];
		valid_2 = slot_v[1];
	endtask

	// One clock: sample strobes, take the edge, then retire accepted slots
	task automatic cycle_step();
		bit a1;
		bit a2;
		@(negedge clk);
		a1 = issue_1;
		a2 = issue_2;
		@(posedge clk);
		#1;
		accepted += int'(a1) + int'(a2);
		if (a1 && a2) begin
			slot_v[0] = 1'b0;
			slot_v[1] = 1'b0;
		end else if (a1) begin
			slot[0] = slot[1];
			slot_v[0] = slot_v[1];
			slot_v[1] = 1'b0;
		end else if (a2) begin
			slot_v[1] = 1'b0;
		end
		if (!slot_v[0] && slot_v[1]) begin
			slot[0] = slot[1];
			slot_v[0] = 1'b1;
			slot_v[1] = 1'b0;
		end
		present();
	endtask

	task automatic send(input issue_pkg::renamed_instr_t a, input bit va,
		input issue_pkg::renamed_instr_t b, input bit vb);
		int n;
		n = 0;
		slot[0] = a;
		slot_v[0] = va;
		slot[1] = b;
		slot_v[1] = vb;
		present();
		while ((slot_v[0] || slot_v[1]) && n < 50) begin
			cycle_step();
			n++;
		end
		if (slot_v[0] || slot_v[1]) begin
			$display("Timeout: instruction not accepted within 50 cycles");
			errors++;
			slot_v[0] = 1'b0;
			slot_v[1] = 1'b0;
			present();
		end
	endtask

	function automatic bit idle();
		bit r;
		r = (accepted == mon_issued) && !slot_v[0] && !slot_v[1];
		for (int i = 0; i < 64; i++) begin
			if (inflight[i] || wb_wait[i]) begin
				r = 1'b0;
			end
		end
		return r;
	endfunction

	task automatic drain(input int limit);
		int n;
		n = 0;
		while (!idle() && n < limit) begin
			cycle_step();
			n++;
		end
		if (!idle()) begin
			$display("Timeout: instructions still in flight after %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished, errors so far %0d", name, errors + mon_errors);
	endtask

	task automatic observe(input issue_pkg::exec_t e, input issue_pkg::fu_e port,
		input logic busy);
		logic [5:0] d;
		issue_pkg::op_e op;
		if (e.valid) begin
			d = e.dest;
			if (busy) begin
				$display("Exec output valid while its busy input is high");
				errors++;
			end
			if (unit[d] != port) begin
				$display("Instruction for dest %0d issued from the wrong station", d);
				errors++;
			end
			if (inflight[src_a[d]] || inflight[src_b[d]]) begin
				$display("Instruction for dest %0d issued before its source was written", d);
				errors++;
			end
			readers[src_a[d]]--;
			readers[src_b[d]]--;
			op = (port == issue_pkg::fu_mem) ? issue_pkg::op_add : e.op;
			wb_data[d] = ref_alu(op, e.data1, e.data2);
			wb_delay[d] = 1 + int'(next_rand() % 4);
			wb_wait[d] = 1'b1;
		end
	endtask

	// Functional-unit model
	always @(negedge clk) begin
		if (rst_n) begin
			observe(exec_int, issue_pkg::fu_int, busy_int);
			observe(exec_mem, issue_pkg::fu_mem, busy_mem);
		end
	end

	always @(posedge clk) begin
		int n;
		// Results written on this edge release their tags
		for (int p = 0; p < 2; p++) begin
			if (wb[p].valid) begin
				inflight[wb[p].dest] = 1'b0;
			end
		end
		#1;
		wb = '0;
		n = 0;
		for (int d = 1; d < 64; d++) begin
			if (wb_wait[d]) begin
				if (wb_delay[d] > 1) begin
					wb_delay[d]--;
				end else if (n < 2) begin
					wb[n].valid = 1'b1;
					wb[n].dest = 6'(d);
					wb[n].data = wb_data[d];
					wb_wait[d] = 1'b0;
					n++;
				end
			end
		end
	end

	initial begin
		issue_pkg::renamed_instr_t ra;
		issue_pkg::renamed_instr_t rb;
		logic [5:0] d0;
		logic [5:0] d1;
		logic [5:0] d2;
		bit ok;
		int gen;
		int cyc;
		int base;

		seed = 32'he13f;
		errors = 0;
		accepted = 0;
		rst_n = 1'b0;
		instr = '0;
		valid_1 = 1'b0;
		valid_2 = 1'b0;
		wb = '0;
		busy_int = 1'b0;
		busy_mem = 1'b0;
		slot_v[0] = 1'b0;
		slot_v[1] = 1'b0;
		for (int i = 0; i < 64; i++) begin
			inflight[i] = 1'b0;
			readers[i] = 0;
			wb_wait[i] = 1'b0;
			src_a[i] = '0;
			src_b[i] = '0;
			unit[i] = issue_pkg::fu_int;
		end
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Quiet after reset
		repeat (10) begin
			@(negedge clk);
			if (issue_1 || issue_2 || exec_int.valid || exec_mem.valid) begin
				$display("Output active after reset with no valid instruction");
				errors++;
			end
			@(posedge clk);
			#1;
		end
		report_test("reset");

		pick_dest(ok, d0);
		make_instr(issue_pkg::fu_int, issue_pkg::op_add, d0, 6'd0, 1'b1, 32'h1234_5678, ra);
		send(ra, 1'b1, rb, 1'b0);
		drain(100);
		pick_dest(ok, d1);
		make_instr(issue_pkg::fu_mem, issue_pkg::op_xor, d1, d0, 1'b1, 32'h40, ra);
		send(ra, 1'b1, rb, 1'b0);
		drain(100);
		report_test("single");

		pick_dest(ok, d1);
		make_instr(issue_pkg::fu_int, issue_pkg::op_sub, d1, d0, 1'b1, 32'h5, ra);
		pick_dest(ok, d2);
		make_instr(issue_pkg::fu_int, issue_pkg::op_add, d2, d1, 1'b0, {26'd0, d0}, rb);
		send(ra, 1'b1, rb, 1'b1);
		drain(100);
		report_test("dependent pair");

		pick_dest(ok, d2);
		make_instr(issue_pkg::fu_int, issue_pkg::op_and, d2, d1, 1'b1, 32'hffff_0f0f, ra);
		send(ra, 1'b1, rb, 1'b0);
		drain(100);
		report_test("immediate");

		busy_int = 1'b1;
		base = mon_issued;
		repeat (3) begin
			pick_dest(ok, d2);
			make_instr(issue_pkg::fu_int, issue_pkg::op_xor, d2, d0, 1'b1, next_rand(), ra);
			send(ra, 1'b1, rb, 1'b0);
		end
		repeat (20) cycle_step();
		busy_int = 1'b0;
		drain(100);
		if (mon_issued - base != 3) begin
			$display("Busy test issued %0d instructions instead of 3", mon_issued - base);
			errors++;
		end
		report_test("busy");

		gen = 0;
		cyc = 0;
		base = accepted;
		while ((gen < 200 || slot_v[0] || slot_v[1]) && cyc < 20000) begin
			for (int s = 0; s < 2; s++) begin
				if (!slot_v[s] && gen < 200 && next_rand() % 4 != 0) begin
					gen_random(ok, slot[s]);
					if (ok) begin
						slot_v[s] = 1'b1;
						gen++;
					end
				end
			end
			busy_int = (next_rand() % 4 == 0);
			busy_mem = (next_rand() % 4 == 0);
			present();
			cycle_step();
			cyc++;
		end
		if (gen < 200 || slot_v[0] || slot_v[1]) begin
			$display("Timeout: random stream stalled after %0d instructions", gen);
			errors++;
		end
		busy_int = 1'b0;
		busy_mem = 1'b0;
		drain(500);
		if (accepted - base != gen) begin
			$display("Random stream accepted %0d of %0d instructions", accepted - base, gen);
			errors++;
		end
		report_test("random");

		$display("accepted %0d issued %0d errors %0d", accepted, mon_issued,
			errors + mon_errors);
		if (errors + mon_errors == 0 && accepted == mon_issued) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
logic/issue_pkg.sv
logic/reg_status.sv
logic/phys_regfile.sv
logic/dispatch_router.sv
logic/reservation_station.sv
logic/issue_stage.sv
verification/issue_chk.sv
verification/issue_monitor.sv
verification/issue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= issue_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT = ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
